/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_machine_wiring -f sources.f \
    && ./obj_dir/Vtb_machine_wiring | tee /dev/stderr | grep "TEST PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD = 4; // 8 ns clock.
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1; // released just after an edge.
    end

endmodule

`default_nettype wire

/* sim/tb_machine_wiring.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_machine_wiring;
    import machine_pkg::*;

    localparam int SEED = 39535;
    localparam int NUM_LINES = 16;
    localparam int HOLD_CYCLES = 200;
    localparam int IDLE_CYCLES = 20;
    localparam int TIMEOUT_CYCLES = NUM_LINES * ((1 << MAX_BUTTONS) + 128) + HOLD_CYCLES + 1000;
    localparam int LIGHTS_RANDOM = 0;
    localparam int LIGHTS_ZERO = 1;
    localparam int LIGHTS_REACHABLE = 2;
    localparam int LIGHTS_NONZERO = 3;
    localparam int LIGHTS_EXTRA = 4; // lights equal to the last, possibly dropped, button.
    localparam int LINE_BUTTONS [NUM_LINES] = '{0, 0, 2, 3, 1, 2, 13, 14, 16, 5, 9, 0, 11, 4, 13, 7};
    localparam int LINE_LIGHTS [NUM_LINES] = '{1, 3, 2, 0, 2, 0, 2, 2, 4, 2, 0, 2, 2, 3, 0, 2};

    logic                    clk;
    logic                    rst_n;
    logic                    wiring_valid;
    logic                    end_of_line;
    logic [WIRING_WIDTH-1:0] wiring_data;
    logic                    result_credit;
    logic                    wiring_credit;
    logic                    result_valid;
    logic                    result_found;
    logic [MAX_BUTTONS-1:0]  result_buttons;
    logic [PRESS_WIDTH-1:0]  result_presses;

    logic                    exp_found [$];
    logic [MAX_BUTTONS-1:0]  exp_mask [$];
    logic [PRESS_WIDTH-1:0]  exp_presses [$];
    logic [WIRING_WIDTH-1:0] button_words [32];
    logic                    hold_results;
    logic                    stim_started;
    logic                    sender_done;
    int                      sender_credits;
    int                      dut_credits; // result credits the DUT holds as the consumer sees it.
    int                      words_sent;
    int                      credits_returned;
    int                      results_seen;
    int                      result_errors;
    int                      credit_errors;
    int                      other_errors;
    int                      cycle_count;

    clock_gen u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    machine_wiring_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .wiring_valid   (wiring_valid),
        .end_of_line    (end_of_line),
        .wiring_data    (wiring_data),
        .result_credit  (result_credit),
        .wiring_credit  (wiring_credit),
        .result_valid   (result_valid),
        .result_found   (result_found),
        .result_buttons (result_buttons),
        .result_presses (result_presses)
    );

    // brute force over every mask, keeping the lowest mask among the fewest presses.
    task automatic find_best_presses(
        input  logic [WIRING_WIDTH-1:0] lights,
        input  int                      kept,
        output logic                    found,
        output logic [MAX_BUTTONS-1:0]  best_mask,
        output logic [PRESS_WIDTH-1:0]  best_presses
    );
        logic [WIRING_WIDTH-1:0] toggled;
        int                      fewest;
        found = 1'b0;
        best_mask = '0;
        best_presses = '0;
        fewest = MAX_BUTTONS + 1;
        for (int m = 0; m < (1 << kept); m++) begin
            toggled = '0;
            for (int b = 0; b < kept; b++) begin
                if (m[b]) begin
                    toggled = toggled ^ button_words[b];
                end
            end
            if (toggled == lights && $countones(m) < fewest) begin
                fewest = $countones(m);
                found = 1'b1;
                best_mask = MAX_BUTTONS'(m);
                best_presses = PRESS_WIDTH'(fewest);
            end
        end
    endtask

    task automatic send_word(input logic [WIRING_WIDTH-1:0] data, input logic last);
        while (sender_credits == 0) begin
            @(posedge clk);
            #1;
        end
        wiring_valid = 1'b1;
        wiring_data = data;
        end_of_line = last;
        sender_credits--;
        words_sent++;
        @(posedge clk);
        #1;
        wiring_valid = 1'b0;
        end_of_line = 1'b0;
    endtask

    task automatic send_line(input int n_buttons, input int light_mode);
        logic [WIRING_WIDTH-1:0] lights;
        logic [MAX_BUTTONS-1:0]  pick;
        int                      kept;
        logic                    e_found;
        logic [MAX_BUTTONS-1:0]  e_mask;
        logic [PRESS_WIDTH-1:0]  e_presses;
        kept = (n_buttons > MAX_BUTTONS) ? MAX_BUTTONS : n_buttons;
        for (int i = 0; i < n_buttons; i++) begin
            button_words[i] = WIRING_WIDTH'($urandom);
        end
        pick = MAX_BUTTONS'($urandom);
        lights = WIRING_WIDTH'($urandom);
        case (light_mode)
            LIGHTS_RANDOM: ; // the random draw stands.
            LIGHTS_ZERO: lights = '0;
            LIGHTS_NONZERO: lights[0] = 1'b1;
            LIGHTS_EXTRA: lights = button_words[n_buttons - 1];
            LIGHTS_REACHABLE: begin
                lights = '0;
                for (int b = 0; b < kept; b++) begin
                    if (pick[b]) begin
                        lights = lights ^ button_words[b];
                    end
                end
            end
            default: ;
        endcase
        find_best_presses(lights, kept, e_found, e_mask, e_presses);
        exp_found.push_back(e_found);
        exp_mask.push_back(e_mask);
        exp_presses.push_back(e_presses);
        send_word(lights, n_buttons == 0);
        for (int i = 0; i < n_buttons; i++) begin
            send_word(button_words[i], i == n_buttons - 1);
        end
    endtask

    task automatic send_all_lines();
        for (int n = 0; n < NUM_LINES; n++) begin
            send_line(LINE_BUTTONS[n], LINE_LIGHTS[n]);
        end
        sender_done = 1'b1;
    endtask

    task automatic check_result();
        logic                   e_found;
        logic [MAX_BUTTONS-1:0] e_mask;
        logic [PRESS_WIDTH-1:0] e_presses;
        assert (dut_credits > 0) else begin
            credit_errors++;
            $display("result_valid was raised while the DUT held no result credit");
        end
        dut_credits--;
        assert (result_found || (result_buttons == '0 && result_presses == '0)) else begin
            result_errors++;
            $display("ERR result_buttons 0x%0h result_presses 0x%0h with result_found low",
                     result_buttons, result_presses);
        end
        if (exp_found.size() == 0) begin
            other_errors++;
            $display("a result arrived with no line outstanding");
        end else begin
            e_found = exp_found.pop_front();
            e_mask = exp_mask.pop_front();
            e_presses = exp_presses.pop_front();
            assert (result_found == e_found) else begin
                result_errors++;
                $display("ERR result_found line %0d: got 0x%0h expected 0x%0h",
                         results_seen, result_found, e_found);
            end
            assert (result_buttons == e_mask) else begin
                result_errors++;
                $display("ERR result_buttons line %0d: got 0x%0h expected 0x%0h",
                         results_seen, result_buttons, e_mask);
            end
            assert (result_presses == e_presses) else begin
                result_errors++;
                $display("ERR result_presses line %0d: got 0x%0h expected 0x%0h",
                         results_seen, result_presses, e_presses);
            end
        end
        results_seen++;
    endtask

    always @(negedge clk) begin
        if (rst_n && !stim_started) begin
            assert (!wiring_credit && !result_valid) else begin
                other_errors++;
                $display("DUT output went active before any stimulus");
            end
        end
        if (rst_n && wiring_credit) begin
            sender_credits++;
            credits_returned++;
            assert (sender_credits <= INPUT_CREDITS) else begin
                credit_errors++;
                $display("ERR sender_credits: got 0x%0h limit 0x%0h",
                         sender_credits, INPUT_CREDITS);
            end
        end
        if (rst_n && result_valid) begin
            check_result();
        end
    end

    // the consumer hands back one credit per cycle unless it is holding them.
    initial begin
        result_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!hold_results && dut_credits < RESULT_CREDITS) begin
                result_credit = 1'b1;
                dut_credits++;
            end else begin
                result_credit = 1'b0;
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, %0d of %0d results seen",
                 cycle_count, results_seen, NUM_LINES);
        $display("errors: result %0d, credit %0d, other %0d",
                 result_errors, credit_errors, other_errors);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        wiring_valid = 1'b0;
        end_of_line = 1'b0;
        wiring_data = '0;
        hold_results = 1'b1;
        stim_started = 1'b0;
        sender_done = 1'b0;
        sender_credits = INPUT_CREDITS;
        dut_credits = RESULT_CREDITS;
        words_sent = 0;
        credits_returned = 0;
        results_seen = 0;
        result_errors = 0;
        credit_errors = 0;
        other_errors = 0;
        void'($urandom(SEED));
        @(posedge rst_n);
        repeat (4) @(posedge clk);
        #1;
        stim_started = 1'b1;
        fork
            send_all_lines();
        join_none
        while (results_seen < RESULT_CREDITS) begin
            @(posedge clk);
        end
        repeat (HOLD_CYCLES) @(posedge clk); // short lines would all be done by now.
        assert (results_seen <= RESULT_CREDITS) else begin
            credit_errors++;
            $display("ERR results_seen while held: got 0x%0h limit 0x%0h",
                     results_seen, RESULT_CREDITS);
        end
        assert (sender_credits == 0) else begin
            credit_errors++;
            $display("ERR sender_credits while held: got 0x%0h expected 0x0", sender_credits);
        end
        hold_results = 1'b0;
        while (results_seen < NUM_LINES || !sender_done) begin
            @(posedge clk);
        end
        repeat (IDLE_CYCLES) @(posedge clk);
        assert (credits_returned == words_sent) else begin
            credit_errors++;
            $display("ERR credits_returned: got 0x%0h expected 0x%0h",
                     credits_returned, words_sent);
        end
        assert (sender_credits == INPUT_CREDITS) else begin
            credit_errors++;
            $display("ERR sender_credits: got 0x%0h expected 0x%0h",
                     sender_credits, INPUT_CREDITS);
        end
        $display("errors: result %0d, credit %0d, other %0d",
                 result_errors, credit_errors, other_errors);
        if (result_errors + credit_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
verilog/machine_pkg.sv
verilog/wiring_fifo.sv
verilog/line_capture.sv
verilog/wiring_ram_arbiter.sv
verilog/wiring_ram.sv
verilog/combination_solver.sv
verilog/machine_wiring_top.sv
sim/clock_gen.sv
sim/tb_machine_wiring.sv

/* verilog/combination_solver.sv */
`timescale 1ns/1ps
`default_nettype none

module combination_solver (
    input  wire                                       clk,
    input  wire                                       rst_n,
    input  wire                                       line_ready,
    input  wire                                       line_bank,
    input  wire [machine_pkg::BUTTON_COUNT_WIDTH-1:0] line_buttons,
    input  wire                                       grant,
    input  wire [machine_pkg::WIRING_WIDTH-1:0]       rdata,
    input  wire                                       result_credit,
    output logic                                      req,
    output logic [machine_pkg::RAM_ADDR_WIDTH-1:0]    addr,
    output logic                                      bank_release,
    output logic                                      result_valid,
    output logic                                      result_found,
    output logic [machine_pkg::MAX_BUTTONS-1:0]       result_buttons,
    output logic [machine_pkg::PRESS_WIDTH-1:0]       result_presses
);
    import machine_pkg::*;

    solver_state_t                  state;
    logic                           bank;
    logic [BUTTON_COUNT_WIDTH-1:0]  nbuttons;
    logic [OFFSET_WIDTH-1:0]        issue_idx; // next word to request.
    logic                           rd_valid;
    logic [OFFSET_WIDTH-1:0]        rd_idx; // word arriving on rdata.
    logic [WIRING_WIDTH-1:0]        lights;
    logic [WIRING_WIDTH-1:0]        buttons [MAX_BUTTONS];
    logic [MAX_BUTTONS-1:0]         mask;
    logic [MAX_BUTTONS-1:0]         last_mask;
    logic [WIRING_WIDTH-1:0]        sel_xor;
    logic [PRESS_WIDTH-1:0]         sel_count;
    logic [RESULT_CREDIT_WIDTH-1:0] credits;

    assign req = (state == SOL_LOAD) && (issue_idx <= nbuttons);
    assign addr = {bank, issue_idx};
    assign bank_release = (state == SOL_LOAD) && rd_valid && (rd_idx == nbuttons);
    assign result_valid = (state == SOL_REPORT) && (credits != '0);
    assign last_mask = MAX_BUTTONS'((1 << nbuttons) - 1);

    // toggles and press count of the mask under test.
    always_comb begin
        sel_xor = '0;
        sel_count = '0;
        for (int i = 0; i < MAX_BUTTONS; i++) begin
            if (mask[i]) begin
                sel_xor = sel_xor ^ buttons[i];
                sel_count = sel_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == SOL_LOAD && rd_valid) begin
            if (rd_idx == '0) begin
                lights <= rdata;
            end else begin
                buttons[rd_idx - 1'b1] <= rdata;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SOL_IDLE;
            bank <= 1'b0;
            nbuttons <= '0;
            issue_idx <= '0;
            rd_valid <= 1'b0;
            rd_idx <= '0;
            mask <= '0;
            result_found <= 1'b0;
            result_buttons <= '0;
            result_presses <= '0;
            credits <= RESULT_CREDIT_WIDTH'(RESULT_CREDITS);
        end else begin
            rd_valid <= grant;
            rd_idx <= issue_idx;
            credits <= credits + RESULT_CREDIT_WIDTH'(result_credit)
                               - RESULT_CREDIT_WIDTH'(result_valid);
            case (state)
                SOL_IDLE: begin
                    if (line_ready) begin
                        state <= SOL_LOAD;
                        bank <= line_bank;
                        nbuttons <= line_buttons;
                        issue_idx <= '0;
                        mask <= '0;
                        result_found <= 1'b0;
                        result_buttons <= '0;
                        result_presses <= '0;
                    end
                end
                SOL_LOAD: begin
                    if (grant) begin
                        issue_idx <= issue_idx + 1'b1;
                    end
                    if (bank_release) begin
                        state <= SOL_SEARCH;
                    end
                end
                SOL_SEARCH: begin
                    // masks rise, so the first of the fewest presses is the lowest mask.
                    if (sel_xor == lights && (!result_found || sel_count < result_presses)) begin
                        result_found <= 1'b1;
                        result_buttons <= mask;
                        result_presses <= sel_count;
                    end
                    if (mask == last_mask) begin
                        state <= SOL_REPORT;
                    end else begin
                        mask <= mask + 1'b1;
                    end
                end
                SOL_REPORT: begin
                    if (result_valid) begin
                        state <= SOL_IDLE;
                    end
                end
                default: state <= SOL_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/line_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module line_capture (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire                                      word_available,
    input  wire [machine_pkg::WIRING_WIDTH-1:0]       word_data,
    input  wire                                      word_last,
    input  wire                                      grant,
    input  wire                                      bank_release,
    output logic                                     pop,
    output logic                                     req,
    output logic                                     we,
    output logic [machine_pkg::RAM_ADDR_WIDTH-1:0]    addr,
    output logic [machine_pkg::WIRING_WIDTH-1:0]      wdata,
    output logic                                     line_ready,
    output logic                                     line_bank,
    output logic [machine_pkg::BUTTON_COUNT_WIDTH-1:0] line_buttons
);
    import machine_pkg::*;

    capture_state_t                state;
    capture_state_t                next_state;
    logic                          cur_bank;
    logic [1:0]                    bank_held;
    logic [BUTTON_COUNT_WIDTH-1:0] count;
    logic                          room; // the bank still has a free button slot.

    assign room = (count < MAX_BUTTONS);
    assign we = req;
    assign wdata = word_data;
    assign line_ready = |bank_held; // at most one bank waits for the solver.

    always_comb begin
        next_state = state;
        req = 1'b0;
        pop = 1'b0;
        addr = {cur_bank, OFFSET_WIDTH'(0)};
        case (state)
            CAP_LIGHT: begin
                req = word_available;
                pop = grant;
                if (grant) begin
                    next_state = word_last ? CAP_STALL : CAP_BUTTONS;
                end
            end
            CAP_BUTTONS: begin
                addr = {cur_bank, OFFSET_WIDTH'(count + 1'b1)};
                if (room) begin
                    req = word_available;
                    pop = grant;
                end else begin
                    pop = word_available; // extra buttons are dropped.
                end
                if (pop && word_last) begin
                    next_state = CAP_STALL;
                end
            end
            CAP_STALL: begin
                if (!bank_held[~cur_bank]) begin
                    next_state = CAP_LIGHT;
                end
            end
            default: next_state = CAP_LIGHT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CAP_LIGHT;
            cur_bank <= 1'b0;
            bank_held <= 2'b00;
            count <= '0;
            line_bank <= 1'b0;
            line_buttons <= '0;
        end else begin
            state <= next_state;
            if (bank_release) begin
                bank_held[line_bank] <= 1'b0;
            end
            if (state == CAP_LIGHT && grant) begin
                count <= '0;
            end
            if (state == CAP_BUTTONS && pop && room) begin
                count <= count + 1'b1;
            end
            if (state == CAP_STALL && !bank_held[~cur_bank]) begin
                bank_held[cur_bank] <= 1'b1; // hand the filled bank over.
                line_bank <= cur_bank;
                line_buttons <= count;
                cur_bank <= ~cur_bank;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/machine_pkg.sv */
`default_nettype none

package machine_pkg;

    localparam int WIRING_WIDTH = 10; // one bit per light.
    localparam int MAX_BUTTONS = 13;
    localparam int PRESS_WIDTH = 4;
    localparam int BANK_WORDS = 16; // light word plus the button words.
    localparam int RAM_ADDR_WIDTH = 5; // top bit picks the bank.
    localparam int OFFSET_WIDTH = RAM_ADDR_WIDTH - 1;
    localparam int BUTTON_COUNT_WIDTH = 4;

    localparam int INPUT_CREDITS = 4; // also the FIFO depth.
    localparam int FIFO_PTR_WIDTH = $clog2(INPUT_CREDITS);
    localparam int FIFO_COUNT_WIDTH = $clog2(INPUT_CREDITS + 1);

    localparam int RESULT_CREDITS = 2;
    localparam int RESULT_CREDIT_WIDTH = $clog2(RESULT_CREDITS + 1);

    typedef enum logic [1:0] {
        CAP_LIGHT,
        CAP_BUTTONS,
        CAP_STALL
    } capture_state_t;

    typedef enum logic [1:0] {
        SOL_IDLE,
        SOL_LOAD,
        SOL_SEARCH,
        SOL_REPORT
    } solver_state_t;

endpackage

`default_nettype wire

/* verilog/machine_wiring_top.sv */
`timescale 1ns/1ps
`default_nettype none

module machine_wiring_top (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 wiring_valid,
    input  wire                                 end_of_line,
    input  wire [machine_pkg::WIRING_WIDTH-1:0] wiring_data,
    input  wire                                 result_credit,
    output logic                                wiring_credit,
    output logic                                result_valid,
    output logic                                result_found,
    output logic [machine_pkg::MAX_BUTTONS-1:0] result_buttons,
    output logic [machine_pkg::PRESS_WIDTH-1:0] result_presses
);
    import machine_pkg::*;

    logic                          word_available;
    logic [WIRING_WIDTH-1:0]       word_data;
    logic                          word_last;
    logic                          pop;
    logic                          cap_req;
    logic                          cap_we;
    logic [RAM_ADDR_WIDTH-1:0]     cap_addr;
    logic [WIRING_WIDTH-1:0]       cap_wdata;
    logic                          cap_grant;
    logic                          sol_req;
    logic [RAM_ADDR_WIDTH-1:0]     sol_addr;
    logic                          sol_grant;
    logic                          line_ready;
    logic                          line_bank;
    logic [BUTTON_COUNT_WIDTH-1:0] line_buttons;
    logic                          bank_release;
    logic                          ram_en;
    logic                          ram_we;
    logic [RAM_ADDR_WIDTH-1:0]     ram_addr;
    logic [WIRING_WIDTH-1:0]       ram_wdata;
    logic [WIRING_WIDTH-1:0]       ram_rdata;

    wiring_fifo u_fifo (
        .clk            (clk),
        .rst_n          (rst_n),
        .wiring_valid   (wiring_valid),
        .end_of_line    (end_of_line),
        .wiring_data    (wiring_data),
        .pop            (pop),
        .word_available (word_available),
        .word_data      (word_data),
        .word_last      (word_last),
        .wiring_credit  (wiring_credit)
    );

    line_capture u_capture (
        .clk            (clk),
        .rst_n          (rst_n),
        .word_available (word_available),
        .word_data      (word_data),
        .word_last      (word_last),
        .grant          (cap_grant),
        .bank_release   (bank_release),
        .pop            (pop),
        .req            (cap_req),
        .we             (cap_we),
        .addr           (cap_addr),
        .wdata          (cap_wdata),
        .line_ready     (line_ready),
        .line_bank      (line_bank),
        .line_buttons   (line_buttons)
    );

    wiring_ram_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .cap_req   (cap_req),
        .cap_we    (cap_we),
        .cap_addr  (cap_addr),
        .cap_wdata (cap_wdata),
        .sol_req   (sol_req),
        .sol_addr  (sol_addr),
        .cap_grant (cap_grant),
        .sol_grant (sol_grant),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata)
    );

    wiring_ram u_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    combination_solver u_solver (
        .clk            (clk),
        .rst_n          (rst_n),
        .line_ready     (line_ready),
        .line_bank      (line_bank),
        .line_buttons   (line_buttons),
        .grant          (sol_grant),
        .rdata          (ram_rdata),
        .result_credit  (result_credit),
        .req            (sol_req),
        .addr           (sol_addr),
        .bank_release   (bank_release),
        .result_valid   (result_valid),
        .result_found   (result_found),
        .result_buttons (result_buttons),
        .result_presses (result_presses)
    );

endmodule

`default_nettype wire

/* verilog/wiring_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module wiring_fifo (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                wiring_valid,
    input  wire                                end_of_line,
    input  wire [machine_pkg::WIRING_WIDTH-1:0] wiring_data,
    input  wire                                pop,
    output logic                               word_available,
    output logic [machine_pkg::WIRING_WIDTH-1:0] word_data,
    output logic                               word_last,
    output logic                               wiring_credit
);
    import machine_pkg::*;

    logic [WIRING_WIDTH:0]       mem [INPUT_CREDITS]; // last flag on top of the word.
    logic [FIFO_PTR_WIDTH-1:0]   wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0]   rd_ptr;
    logic [FIFO_COUNT_WIDTH-1:0] count;
    logic                        do_pop;

    assign do_pop = pop && word_available;
    assign word_available = (count != '0);
    assign word_data = mem[rd_ptr][WIRING_WIDTH-1:0];
    assign word_last = mem[rd_ptr][WIRING_WIDTH];

    always_ff @(posedge clk) begin
        if (wiring_valid) begin
            mem[wr_ptr] <= {end_of_line, wiring_data};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            wiring_credit <= 1'b0;
        end else begin
            if (wiring_valid) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, so it wraps.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + FIFO_COUNT_WIDTH'(wiring_valid) - FIFO_COUNT_WIDTH'(do_pop);
            wiring_credit <= do_pop; // one credit back per word that leaves.
        end
    end

endmodule

`default_nettype wire

/* verilog/wiring_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module wiring_ram (
    input  wire                                   clk,
    input  wire                                   en,
    input  wire                                   we,
    input  wire [machine_pkg::RAM_ADDR_WIDTH-1:0] addr,
    input  wire [machine_pkg::WIRING_WIDTH-1:0]   wdata,
    output logic [machine_pkg::WIRING_WIDTH-1:0]  rdata
);
    import machine_pkg::*;

    logic [WIRING_WIDTH-1:0] mem [2 * BANK_WORDS];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr]; // read data follows the access by one cycle.
        end
    end

endmodule

`default_nettype wire

/* verilog/wiring_ram_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wiring_ram_arbiter (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   cap_req,
    input  wire                                   cap_we,
    input  wire [machine_pkg::RAM_ADDR_WIDTH-1:0] cap_addr,
    input  wire [machine_pkg::WIRING_WIDTH-1:0]   cap_wdata,
    input  wire                                   sol_req,
    input  wire [machine_pkg::RAM_ADDR_WIDTH-1:0] sol_addr,
    output logic                                  cap_grant,
    output logic                                  sol_grant,
    output logic                                  ram_en,
    output logic                                  ram_we,
    output logic [machine_pkg::RAM_ADDR_WIDTH-1:0] ram_addr,
    output logic [machine_pkg::WIRING_WIDTH-1:0]   ram_wdata
);
    import machine_pkg::*;

    logic last_sol; // the solver won the most recent grant.

    // capture wins when alone or when the solver had the last turn.
    assign cap_grant = cap_req && (!sol_req || last_sol);
    assign sol_grant = sol_req && !cap_grant;

    assign ram_en = cap_grant || sol_grant;
    assign ram_we = cap_grant && cap_we;
    assign ram_addr = cap_grant ? cap_addr : sol_addr;
    assign ram_wdata = cap_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_sol <= 1'b0;
        end else if (ram_en) begin
            last_sol <= sol_grant;
        end
    end

endmodule

`default_nettype wire
